/* design/align_job_if.sv */
interface align_job_if
    import sw_stream_pkg::*, sw_score_pkg::*;
();

    // Handshake, job moves when both high
    logic                              job_valid;
    logic                              job_rdy;

    // Sequences, base 0 in the low bits
    logic [MAX_QUERY_LEN*BASE_W-1:0]   query;
    logic [Q_POS_W-1:0]                query_len;
    logic [MAX_TARGET_LEN*BASE_W-1:0]  target;
    logic [T_POS_W-1:0]                target_len;

    // Prior score, seeds the border
    score_t                            h0;

    modport splitter (
        output job_valid, query, query_len, target, target_len, h0,
        input  job_rdy
    );

    modport engine (
        input  job_valid, query, query_len, target, target_len, h0,
        output job_rdy
    );

endinterface

/* design/nw_align_engine.sv */
module nw_align_engine
    import sw_stream_pkg::*, sw_score_pkg::*;
(
    input  logic        PicoClk,
    input  logic        rst_n,

    align_job_if.engine job,

    output logic        score_valid,
    output score_t      score,
    input  logic        score_taken
);

    logic                                  busy;
    logic                                  start;
    logic                                  last_cell;
    logic [MAX_QUERY_LEN-1:0][BASE_W-1:0]  q;
    logic [MAX_TARGET_LEN-1:0][BASE_W-1:0] t;
    logic [Q_POS_W-1:0]                    q_len;
    logic [Q_POS_W-1:0]                    i;
    logic [T_POS_W-1:0]                    t_len;
    logic [T_POS_W-1:0]                    j;

    // Column j-1 of H, entry 0 already holds H[0][j]
    score_t  row [MAX_QUERY_LEN+1];
    // H[i-1][j-1] and H[i-1][j] of the current cell
    score_t  h_diag;
    score_t  h_up;
    score_t  sub;
    score_t  h;

    function automatic score_t max3(input score_t a, input score_t b, input score_t c);
        score_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // Idle means no job running and no result waiting
    assign job.job_rdy = !busy && !score_valid;
    assign start       = job.job_valid && job.job_rdy;
    assign last_cell   = (i == q_len) && (j == t_len);

    ////////////////////////////////////////////////////////////
    // One cell per cycle
    ////////////////////////////////////////////////////////////

    always_comb begin
        sub = (q[i - 1'b1] == t[j - 1'b1]) ? MATCH_SCORE : MISMATCH_SCORE;
        h   = max3(h_diag + sub, h_up + GAP_SCORE, row[i] + GAP_SCORE);
    end

    always_ff @(posedge PicoClk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            score_valid <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (busy && last_cell) begin
                busy        <= 1'b0;
                score_valid <= 1'b1;
            end else if (score_taken) begin
                score_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge PicoClk) begin
        if (start) begin
            q     <= job.query;
            t     <= job.target;
            q_len <= job.query_len;
            t_len <= job.target_len;
            // Border column H[i][0]
            for (int k = 1; k <= MAX_QUERY_LEN; k++) begin
                row[k] <= job.h0 + score_t'(k) * GAP_SCORE;
            end
            row[0] <= job.h0 + GAP_SCORE;
            h_diag <= job.h0;
            h_up   <= job.h0 + GAP_SCORE;
            i      <= Q_POS_W'(1);
            j      <= T_POS_W'(1);
        end else if (busy) begin
            row[i] <= h;
            if (i == q_len) begin
                if (j == t_len) begin
                    score <= h;
                end
                // Next column starts on the border H[0][j+1]
                i      <= Q_POS_W'(1);
                j      <= j + 1'b1;
                h_diag <= row[0];
                h_up   <= row[0] + GAP_SCORE;
                row[0] <= row[0] + GAP_SCORE;
            end else begin
                i      <= i + 1'b1;
                h_diag <= row[i];
                h_up   <= h;
            end
        end
    end

    // Lengths come from the splitter headers
    a_no_empty_job: assert property (
        @(posedge PicoClk) disable iff (!rst_n)
        job.job_valid |-> (job.query_len != '0 && job.target_len != '0)
    );

endmodule

/* design/pico_smith_waterman.sv */
module pico_smith_waterman
    import sw_stream_pkg::*, sw_score_pkg::*;
(
    input  logic          PicoClk,
    input  logic          rst_n,

    input  logic          in_valid,
    output logic          in_rdy,
    input  stream_word_t  in_data,

    output logic          out_valid,
    input  logic          out_rdy,
    output stream_word_t  out_data,

    input  logic [31:0]   pico_addr,
    input  logic          pico_rd,
    input  logic          pico_wr,
    output logic [31:0]   pico_data_out
);

    ////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////

    align_job_if job_if ();

    // Sideband path
    logic               fifo_wr_en;
    logic [STREAM_W:0]  fifo_din;
    logic               fifo_full;
    logic               fifo_rd_en;
    logic [STREAM_W:0]  fifo_dout;
    logic               fifo_empty;

    // Engine result
    logic               score_valid;
    score_t             score;
    logic               score_taken;

    logic               packet_done;

    stream_splitter splitter_i (
        .PicoClk    (PicoClk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_rdy     (in_rdy),
        .in_data    (in_data),
        .job        (job_if.splitter),
        .fifo_wr_en (fifo_wr_en),
        .fifo_din   (fifo_din),
        .fifo_full  (fifo_full)
    );

    sideband_fifo fifo_i (
        .PicoClk (PicoClk),
        .rst_n   (rst_n),
        .wr_en   (fifo_wr_en),
        .din     (fifo_din),
        .full    (fifo_full),
        .rd_en   (fifo_rd_en),
        .dout    (fifo_dout),
        .empty   (fifo_empty)
    );

    nw_align_engine engine_i (
        .PicoClk     (PicoClk),
        .rst_n       (rst_n),
        .job         (job_if.engine),
        .score_valid (score_valid),
        .score       (score),
        .score_taken (score_taken)
    );

    stream_merger merger_i (
        .PicoClk     (PicoClk),
        .rst_n       (rst_n),
        .fifo_rd_en  (fifo_rd_en),
        .fifo_dout   (fifo_dout),
        .fifo_empty  (fifo_empty),
        .score_valid (score_valid),
        .score       (score),
        .score_taken (score_taken),
        .out_valid   (out_valid),
        .out_rdy     (out_rdy),
        .out_data    (out_data),
        .packet_done (packet_done)
    );

    picobus_regs regs_i (
        .PicoClk       (PicoClk),
        .rst_n         (rst_n),
        .pico_addr     (pico_addr),
        .pico_rd       (pico_rd),
        .pico_wr       (pico_wr),
        .pico_data_out (pico_data_out),
        .packet_done   (packet_done)
    );

endmodule

/* design/picobus_regs.sv */
module picobus_regs
    import sw_stream_pkg::*, sw_score_pkg::*;
(
    input  logic         PicoClk,
    input  logic         rst_n,

    input  logic [31:0]  pico_addr,
    input  logic         pico_rd,
    input  logic         pico_wr,
    output logic [31:0]  pico_data_out,

    input  logic         packet_done
);

    logic [31:0]  pkt_cnt;
    logic [31:0]  offset;

    assign offset = pico_addr - PICOBUS_ADDR;

    // Finished packets, counted at the output
    always_ff @(posedge PicoClk) begin
        if (!rst_n) begin
            pkt_cnt <= '0;
        end else if (packet_done) begin
            pkt_cnt <= pkt_cnt + 32'd1;
        end
    end

    // Answer one cycle after the strobe, zero otherwise
    always_ff @(posedge PicoClk) begin
        if (!rst_n) begin
            pico_data_out <= '0;
        end else if (pico_rd && !pico_wr) begin
            case (offset)
                32'h000: pico_data_out <= VERSION;
                32'h020: pico_data_out <= 32'(NUM_EXTRA_TX);
                32'h030: pico_data_out <= pkt_cnt;
                32'h040: pico_data_out <= 32'(MAX_QUERY_LEN);
                32'h050: pico_data_out <= 32'(Q_POS_W);
                32'h060: pico_data_out <= 32'(MAX_TARGET_LEN);
                32'h070: pico_data_out <= 32'(T_POS_W);
                32'h0A0: pico_data_out <= 32'(SCORE_W);
                32'h0B0: pico_data_out <= 32'(STREAM_W);
                32'h0D0: pico_data_out <= 32'(BASE_W);
                32'h110: pico_data_out <= 32'(LOCAL_ALIGNMENT);
                default: pico_data_out <= '0;
            endcase
        end else begin
            // Writes land here and change nothing
            pico_data_out <= '0;
        end
    end

endmodule

/* design/sideband_fifo.sv */
module sideband_fifo
    import sw_stream_pkg::*;
(
    input  logic                PicoClk,
    input  logic                rst_n,

    input  logic                wr_en,
    input  logic [STREAM_W:0]   din,
    output logic                full,

    input  logic                rd_en,
    output logic [STREAM_W:0]   dout,
    output logic                empty
);

    logic [STREAM_W:0]  mem [FIFO_DEPTH];
    // Extra MSB tells full from empty
    logic [FIFO_AW:0]   wr_ptr;
    logic [FIFO_AW:0]   rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    // Head word always visible
    assign dout = mem[rd_ptr[FIFO_AW-1:0]];

    always_ff @(posedge PicoClk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge PicoClk) begin
        if (wr_en && !full) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= din;
        end
    end

    a_no_overflow: assert property (
        @(posedge PicoClk) disable iff (!rst_n) wr_en |-> !full
    );
    a_no_underflow: assert property (
        @(posedge PicoClk) disable iff (!rst_n) rd_en |-> !empty
    );

endmodule

/* design/stream_merger.sv */
module stream_merger
    import sw_stream_pkg::*, sw_score_pkg::*;
(
    input  logic                PicoClk,
    input  logic                rst_n,

    output logic                fifo_rd_en,
    input  logic [STREAM_W:0]   fifo_dout,
    input  logic                fifo_empty,

    input  logic                score_valid,
    input  score_t              score,
    output logic                score_taken,

    output logic                out_valid,
    input  logic                out_rdy,
    output stream_word_t        out_data,

    output logic                packet_done
);

    // Next FIFO word opens a packet
    logic          first;
    header_word_t  hdr;

    // First word waits for its score
    assign out_valid   = !fifo_empty && (!first || score_valid);
    assign fifo_rd_en  = out_valid && out_rdy;
    assign score_taken = fifo_rd_en && first;
    assign packet_done = fifo_rd_en && fifo_dout[STREAM_W];

    // Score goes into the query header
    always_comb begin
        hdr          = fifo_dout[STREAM_W-1:0];
        hdr.qh.score = score;
    end

    // FIFO head is stable while stalled, so out_data holds
    assign out_data = first ? stream_word_t'(hdr) : fifo_dout[STREAM_W-1:0];

    always_ff @(posedge PicoClk) begin
        if (!rst_n) begin
            first <= 1'b1;
        end else if (fifo_rd_en) begin
            first <= fifo_dout[STREAM_W];
        end
    end

endmodule

/* design/stream_splitter.sv */
module stream_splitter
    import sw_stream_pkg::*, sw_score_pkg::*;
(
    input  logic                PicoClk,
    input  logic                rst_n,

    input  logic                in_valid,
    output logic                in_rdy,
    input  stream_word_t        in_data,

    align_job_if.splitter       job,

    output logic                fifo_wr_en,
    output logic [STREAM_W:0]   fifo_din,
    input  logic                fifo_full
);

    logic              run;
    logic [POS_W-1:0]  pos;
    logic [2:0]        cnt;
    // Index of the last target word, 0 or 1
    logic              t_last;
    header_word_t      hdr;
    logic              take;
    logic              last_word;

    assign hdr = in_data;

    // Hold the next query header until the engine took the job
    assign in_rdy = run && !fifo_full && !(pos == POS_QHDR && job.job_valid);
    assign take   = in_valid && in_rdy;

    assign last_word  = (pos == POS_EXTRA) && (cnt == 3'(NUM_EXTRA_TX - 1));
    assign fifo_wr_en = take;
    assign fifo_din   = {last_word, in_data};

    ////////////////////////////////////////////////////////////
    // Packet position
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PicoClk) begin
        if (!rst_n) begin
            run           <= 1'b0;
            pos           <= POS_QHDR;
            cnt           <= '0;
            job.job_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (job.job_valid && job.job_rdy) begin
                job.job_valid <= 1'b0;
            end
            if (take) begin
                case (pos)
                    POS_QHDR:   pos <= POS_QBASES;
                    POS_QBASES: pos <= POS_THDR;
                    POS_THDR: begin
                        pos <= POS_TBASES;
                        cnt <= '0;
                    end
                    POS_TBASES: begin
                        // Job is complete after the last target word
                        if (cnt[0] == t_last) begin
                            pos           <= POS_EXTRA;
                            cnt           <= '0;
                            job.job_valid <= 1'b1;
                        end else begin
                            cnt <= cnt + 3'd1;
                        end
                    end
                    POS_EXTRA: begin
                        if (last_word) begin
                            pos <= POS_QHDR;
                            cnt <= '0;
                        end else begin
                            cnt <= cnt + 3'd1;
                        end
                    end
                    default: pos <= POS_QHDR;
                endcase
            end
        end
    end

    // Job fields, only written while no job is pending
    always_ff @(posedge PicoClk) begin
        if (take) begin
            case (pos)
                POS_QHDR:   job.query_len <= hdr.qh.query_len[Q_POS_W-1:0];
                POS_QBASES: job.query <= in_data;
                POS_THDR: begin
                    job.target_len <= hdr.th.target_len[T_POS_W-1:0];
                    job.h0         <= score_t'(hdr.th.h0);
                    t_last         <= hdr.th.target_len > 16'(BASES_PER_WORD);
                end
                POS_TBASES: job.target[cnt[0]*STREAM_W +: STREAM_W] <= in_data;
                default: ;
            endcase
        end
    end

    // Pending job and its fields hold until the engine takes it
    a_job_held: assert property (
        @(posedge PicoClk) disable iff (!rst_n)
        job.job_valid && !job.job_rdy |=>
            job.job_valid && $stable({job.query, job.query_len, job.target_len,
                                      job.h0, job.target[STREAM_W-1:0]})
    );

endmodule

/* design/sw_score_pkg.sv */
package sw_score_pkg;

    ////////////////////////////////////////////////////////////
    // Scoring
    ////////////////////////////////////////////////////////////

    localparam int SCORE_W = 16;

    // Signed, wide enough for 16 x 32 cells plus a prior score
    typedef logic signed [SCORE_W-1:0] score_t;

    // Linear gap model, fixed at build time
    localparam score_t MATCH_SCORE    = 16'sd2;
    localparam score_t MISMATCH_SCORE = -16'sd1;
    localparam score_t GAP_SCORE      = -16'sd2;

    // Global alignment only
    localparam int LOCAL_ALIGNMENT = 0;

endpackage

/* design/sw_stream_pkg.sv */
package sw_stream_pkg;

    ////////////////////////////////////////////////////////////
    // Stream geometry
    ////////////////////////////////////////////////////////////

    localparam int STREAM_W       = 32;
    // Bases are 2-bit codes, base 0 in the low bits of a word
    localparam int BASE_W         = 2;
    localparam int BASES_PER_WORD = STREAM_W / BASE_W;

    // Sequence limits and length field widths
    localparam int MAX_QUERY_LEN  = 16;
    localparam int MAX_TARGET_LEN = 32;
    localparam int Q_POS_W        = 5;
    localparam int T_POS_W        = 6;

    // Trailing words copied straight through
    localparam int NUM_EXTRA_TX   = 2;

    // Sideband storage, four packets of up to 7 words
    localparam int FIFO_DEPTH     = 32;
    localparam int FIFO_AW        = $clog2(FIFO_DEPTH);

    // Position inside a packet
    localparam int              POS_W      = 3;
    localparam logic [POS_W-1:0] POS_QHDR   = 3'd0;
    localparam logic [POS_W-1:0] POS_QBASES = 3'd1;
    localparam logic [POS_W-1:0] POS_THDR   = 3'd2;
    localparam logic [POS_W-1:0] POS_TBASES = 3'd3;
    localparam logic [POS_W-1:0] POS_EXTRA  = 3'd4;

    // Bus map
    localparam logic [31:0] PICOBUS_ADDR = 32'h0000_0000;
    localparam logic [31:0] VERSION      = 32'h0000_0101;

    typedef logic [STREAM_W-1:0] stream_word_t;

    // Header word, read as a query header or a target header
    typedef struct packed {
        logic [15:0] score;
        logic [15:0] query_len;
    } query_hdr_t;

    typedef struct packed {
        logic [15:0] h0;
        logic [15:0] target_len;
    } target_hdr_t;

    typedef union packed {
        query_hdr_t  qh;
        target_hdr_t th;
    } header_word_t;

endpackage

/* dv/sw_trace.txt */
# Records: test <name> | in <count> <hex words> | out <count> <hex words, first holds score>
# pkts <packets done so far, closes the test> | reg <name> <hex offset> <hex value>
test identical_8
# ACGTACGT against itself from H0 = 0, score 16
in 6 00000008 5a5ae4e4 00000008 1234e4e4 cafe0001 beef0002
out 6 00100008 5a5ae4e4 00000008 1234e4e4 cafe0001 beef0002
pkts 1
test gap_mismatch_h0
# ACGT against AGG from H0 = 5, one gap and one mismatch, score 6
in 6 dead0004 000000e4 00050003 00000028 11111111 22222222
out 6 00060004 000000e4 00050003 00000028 11111111 22222222
# TT against AAC from H0 = -10, score -14
in 6 00000002 0000000f fff60003 00000010 33333333 44444444
out 6 fff20002 0000000f fff60003 00000010 33333333 44444444
pkts 3
test two_word_target
# ACGT x4 inside T x8, ACGT x4, T x8 across both words, H0 = 100, score 100
in 7 00000010 e4e4e4e4 00640020 e4e4ffff ffffe4e4 55555555 66666666
out 7 00640010 e4e4e4e4 00640020 e4e4ffff ffffe4e4 55555555 66666666
pkts 4
test back_to_back
# A against A, score 2
in 6 00000001 00000000 00000001 00000000 77777777 88888888
out 6 00020001 00000000 00000001 00000000 77777777 88888888
# A against C, score -1
in 6 00000001 00000000 00000001 00000001 99999999 aaaaaaaa
out 6 ffff0001 00000000 00000001 00000001 99999999 aaaaaaaa
# AC against C from H0 = 3, score 3
in 6 00000002 00000004 00030001 00000001 bbbbbbbb cccccccc
out 6 00030002 00000004 00030001 00000001 bbbbbbbb cccccccc
pkts 7
# Bus map, offsets from the bus base address
reg version 0 101
reg extra_words 20 2
reg packet_count 30 7
reg max_query_len 40 10
reg query_pos_w 50 5
reg max_target_len 60 20
reg target_pos_w 70 6
reg score_w a0 10
reg stream_w b0 20
reg base_w d0 2
reg local_alignment 110 0
reg unmapped_10 10 0
reg unmapped_80 80 0
reg unmapped_200 200 0

/* dv/tb_pico_smith_waterman.sv */
module tb_pico_smith_waterman
    import sw_stream_pkg::*, sw_score_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Inputs change this long after the rising edge
    localparam int DRIVE_DLY   = 2;
    // Worst case engine run, longest query times longest target
    localparam int CELL_CYCLES = MAX_QUERY_LEN * MAX_TARGET_LEN;
    localparam int WORD_WAIT   = 4 * CELL_CYCLES;
    localparam int IDLE_CHECK  = 20;

    logic          PicoClk;
    logic          rst_n;
    logic          in_valid;
    logic          in_rdy;
    stream_word_t  in_data;
    logic          out_valid;
    logic          out_rdy;
    stream_word_t  out_data;
    logic [31:0]   pico_addr;
    logic          pico_rd;
    logic          pico_wr;
    logic [31:0]   pico_data_out;

    // Trace contents, one entry per test or per word
    string         test_name [$];
    int            test_in_first [$];
    int            test_in_num [$];
    int            test_out_first [$];
    int            test_out_num [$];
    int            test_pkts [$];
    stream_word_t  in_words [$];
    stream_word_t  exp_words [$];
    bit            exp_first [$];
    string         reg_name [$];
    logic [31:0]   reg_addr [$];
    logic [31:0]   reg_exp [$];

    int            word_errs;
    int            score_errs;
    int            reg_errs;
    int            other_errs;
    integer        seed;
    logic          trace_loaded;

    pico_smith_waterman dut_i (
        .PicoClk       (PicoClk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_rdy        (in_rdy),
        .in_data       (in_data),
        .out_valid     (out_valid),
        .out_rdy       (out_rdy),
        .out_data      (out_data),
        .pico_addr     (pico_addr),
        .pico_rd       (pico_rd),
        .pico_wr       (pico_wr),
        .pico_data_out (pico_data_out)
    );

    initial begin
        PicoClk = 1'b0;
        forever #10 PicoClk = ~PicoClk;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input stream_word_t exp, input stream_word_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, got %h", name, exp, act);
            word_errs++;
        end
    endtask

    task automatic check_score(input string name, input score_t exp, input score_t act);
        if (exp !== act) begin
            $display("Fail %s score: expected %0d, got %0d", name, exp, act);
            score_errs++;
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, got %h", name, exp, act);
            reg_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Trace reader
    ////////////////////////////////////////////////////////////

    task automatic read_trace();
        int                fd;
        int                code;
        int                n;
        int                k;
        int                in0;
        int                out0;
        string             tag;
        string             name;
        logic [31:0]       w;
        logic [31:0]       a;
        logic [8*200-1:0]  skip;
        fd = $fopen("dv/sw_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file dv/sw_trace.txt");
            other_errs++;
            return;
        end
        in0  = 0;
        out0 = 0;
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            if (tag[0] == "#") begin
                code = $fgets(skip, fd);
            end else if (tag == "test") begin
                code = $fscanf(fd, "%s", name);
                in0  = in_words.size();
                out0 = exp_words.size();
            end else if (tag == "in" || tag == "out") begin
                code = $fscanf(fd, "%d", n);
                for (k = 0; k < n; k++) begin
                    code = $fscanf(fd, "%h", w);
                    if (tag == "in") begin
                        in_words.push_back(w);
                    end else begin
                        // First word of each packet carries the score
                        exp_words.push_back(w);
                        exp_first.push_back(k == 0);
                    end
                end
            end else if (tag == "pkts") begin
                // Closes the current test
                code = $fscanf(fd, "%d", n);
                test_name.push_back(name);
                test_in_first.push_back(in0);
                test_in_num.push_back(in_words.size() - in0);
                test_out_first.push_back(out0);
                test_out_num.push_back(exp_words.size() - out0);
                test_pkts.push_back(n);
            end else if (tag == "reg") begin
                code = $fscanf(fd, "%s %h %h", name, a, w);
                reg_name.push_back(name);
                reg_addr.push_back(a);
                reg_exp.push_back(w);
            end else begin
                $display("Unknown record %s in the trace file", tag);
                other_errs++;
            end
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
        if (test_name.size() == 0) begin
            $display("The trace file holds no tests");
            other_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stream and bus drivers
    ////////////////////////////////////////////////////////////

    // Entered and left at DRIVE_DLY after a rising edge
    task automatic drive_inputs(input int t);
        int k;
        for (k = 0; k < test_in_num[t]; k++) begin
            in_valid = 1'b1;
            in_data  = in_words[test_in_first[t] + k];
            @(negedge PicoClk);
            while (!in_rdy) begin
                @(negedge PicoClk);
            end
            @(posedge PicoClk);
            #DRIVE_DLY;
        end
        in_valid = 1'b0;
        in_data  = '0;
    endtask

    // Outputs sampled at the falling edge, a move happens at the next rise
    task automatic collect_outputs(input int t);
        int            k;
        int            idx;
        int            idle;
        logic          taken;
        logic          stalled;
        stream_word_t  held;
        stream_word_t  got;
        header_word_t  exp_h;
        header_word_t  got_h;
        string         name;
        stalled = 1'b0;
        held    = '0;
        got     = '0;
        for (k = 0; k < test_out_num[t]; k++) begin
            name  = $sformatf("%s word %0d", test_name[t], k);
            taken = 1'b0;
            idle  = 0;
            while (!taken && idle < WORD_WAIT) begin
                @(negedge PicoClk);
                // Stalled word must hold
                if (stalled && !out_valid) begin
                    $display("out_valid dropped before %s was taken", name);
                    other_errs++;
                end else if (stalled) begin
                    check_word($sformatf("%s held", name), held, out_data);
                end
                stalled = out_valid && !out_rdy;
                held    = out_data;
                if (out_valid && out_rdy) begin
                    taken = 1'b1;
                    got   = out_data;
                end else begin
                    idle++;
                end
            end
            if (!taken) begin
                $display("Output %s never arrived", name);
                other_errs++;
                return;
            end
            idx = test_out_first[t] + k;
            if (exp_first[idx]) begin
                // Score field of the query header, then its length field
                exp_h = exp_words[idx];
                got_h = got;
                check_score(name, score_t'(exp_h.qh.score), score_t'(got_h.qh.score));
                check_word(name, stream_word_t'(exp_h.qh.query_len),
                           stream_word_t'(got_h.qh.query_len));
            end else begin
                check_word(name, exp_words[idx], got);
            end
        end
    endtask

    task automatic watch_for_extra(input int t);
        logic seen;
        seen = 1'b0;
        repeat (IDLE_CHECK) begin
            @(negedge PicoClk);
            if (out_valid && !seen) begin
                $display("Extra output word %h after test %s", out_data, test_name[t]);
                other_errs++;
                seen = 1'b1;
            end
        end
    endtask

    // One read strobe, answer next cycle, zero the cycle after
    task automatic probe_register(input string name, input logic [31:0] addr,
                                  input logic [31:0] exp);
        logic [31:0] answer;
        logic [31:0] after;
        pico_addr = PICOBUS_ADDR + addr;
        pico_rd   = 1'b1;
        @(posedge PicoClk);
        #DRIVE_DLY;
        pico_rd = 1'b0;
        @(negedge PicoClk);
        answer = pico_data_out;
        @(negedge PicoClk);
        after = pico_data_out;
        @(posedge PicoClk);
        #DRIVE_DLY;
        check_reg(name, exp, answer);
        check_reg($sformatf("%s idle", name), 32'h0, after);
    endtask

    task automatic run_test(input int t);
        fork
            drive_inputs(t);
            collect_outputs(t);
        join
        watch_for_extra(t);
        @(posedge PicoClk);
        #DRIVE_DLY;
        probe_register($sformatf("%s packet count", test_name[t]), 32'h30, test_pkts[t]);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////

    // Random back-pressure on the output stream
    initial begin : rdy_gen
        wait (rst_n === 1'b1);
        forever begin
            @(posedge PicoClk);
            #DRIVE_DLY;
            out_rdy = ($random(seed) & 3) != 0;
        end
    end

    initial begin : watchdog
        int limit;
        wait (trace_loaded === 1'b1);
        limit = 40 * (in_words.size() + exp_words.size() + reg_name.size())
              + 40 * CELL_CYCLES * test_name.size() + 100;
        repeat (limit) @(posedge PicoClk);
        $display("Timeout, the run did not finish within %0d cycles", limit);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : main
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        out_rdy      = 1'b1;
        pico_addr    = '0;
        pico_rd      = 1'b0;
        pico_wr      = 1'b0;
        seed         = 78893;
        word_errs    = 0;
        score_errs   = 0;
        reg_errs     = 0;
        other_errs   = 0;
        trace_loaded = 1'b0;
        read_trace();
        trace_loaded = 1'b1;

        // Reset for 3 cycles, outputs idle meanwhile
        repeat (2) @(posedge PicoClk);
        @(negedge PicoClk);
        if (in_rdy !== 1'b0 || out_valid !== 1'b0 || pico_data_out !== 32'h0) begin
            $display("Outputs not idle in reset: in_rdy %b, out_valid %b, pico_data_out %h",
                     in_rdy, out_valid, pico_data_out);
            other_errs++;
        end
        @(posedge PicoClk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        for (int t = 0; t < test_name.size(); t++) begin
            run_test(t);
        end
        for (int r = 0; r < reg_name.size(); r++) begin
            probe_register(reg_name[r], reg_addr[r], reg_exp[r]);
        end

        $display("Errors: %0d word, %0d score, %0d register, %0d other",
                 word_errs, score_errs, reg_errs, other_errs);
        if (word_errs + score_errs + reg_errs + other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/sw_stream_pkg.sv
design/sw_score_pkg.sv
design/align_job_if.sv
design/stream_splitter.sv
design/sideband_fifo.sv
design/nw_align_engine.sv
design/stream_merger.sv
design/picobus_regs.sv
design/pico_smith_waterman.sv
dv/tb_pico_smith_waterman.sv
